// File: hw/dl_bus_pkg.sv
// bus package for the delay line: AXI4-Lite types, register map and field positions
`default_nettype none

package dl_bus_pkg;

  // AXI4-Lite widths
  localparam int unsigned AXIL_ADDR_W = 4;
  localparam int unsigned AXIL_DATA_W = 32;

  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;

  // register offsets
  localparam axil_addr_t REG_CTRL      = 4'h0;
  localparam axil_addr_t REG_DEPTH     = 4'h4;
  localparam axil_addr_t REG_STATUS    = 4'h8;
  localparam axil_addr_t REG_OUT_COUNT = 4'hC;

  // control bits, clear is write-only and reads as zero
  localparam int unsigned CTRL_ENABLE_BIT = 0;
  localparam int unsigned CTRL_CLEAR_BIT  = 1;

  // status fields
  localparam int unsigned STATUS_LENGTH_LSB = 0;
  localparam int unsigned STATUS_EMPTY_BIT  = 8;
  localparam int unsigned STATUS_FULL_BIT   = 9;

  // legal delay range and reset value of the depth register
  localparam axil_data_t DEPTH_MIN   = 32'd1;
  localparam axil_data_t DEPTH_MAX   = 32'd63;
  localparam axil_data_t DEPTH_RESET = 32'd1;

  // master outputs
  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    axil_data_t wdata;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  // slave outputs, responses are always OKAY so no resp fields
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic       arready;
    axil_data_t rdata;
    logic       rvalid;
  } axil_rsp_t;

endpackage

`default_nettype wire

// File: hw/dl_data_pkg.sv
// data package for the delay line: sample, storage address and length types
`default_nettype none

package dl_data_pkg;

  // one sample on the stream
  localparam int unsigned SAMPLE_W = 32;

  // storage depth in samples
  localparam int unsigned NUM_WORDS = 64;

  // address covers 0..NUM_WORDS-1, length needs one more bit for NUM_WORDS itself
  localparam int unsigned ADDR_W = $clog2(NUM_WORDS);
  localparam int unsigned LEN_W  = $clog2(NUM_WORDS + 1);

  typedef logic [SAMPLE_W-1:0] sample_t;
  typedef logic [ADDR_W-1:0]   sram_addr_t;
  typedef logic [LEN_W-1:0]    length_t;

  // sample with its valid flag, no ready since the output has no back-pressure
  typedef struct packed {
    logic    valid;
    sample_t sample;
  } sample_stream_t;

endpackage

`default_nettype wire

// File: hw/sp_sram.sv
// single-port sample SRAM model with one cycle of read latency
`timescale 1ns/1ps
`default_nettype none

module sp_sram import dl_data_pkg::*; (
  input  wire             clk_i,
  input  wire             req_i,
  input  wire             we_i,
  input  wire sram_addr_t addr_i,
  input  wire sample_t    wdata_i,
  output sample_t         rdata_o
);

  sample_t mem [NUM_WORDS];

  // write port, word lands at the edge
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // read port, rdata holds its value until the next read request
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

// File: hw/sram_shift_reg.sv
// circular shift register on a single-port SRAM, front word always on the read port
`timescale 1ns/1ps
`default_nettype none

module sram_shift_reg import dl_data_pkg::*; (
  input  wire          clk_i,
  input  wire          rst_n_i,
  input  wire          clear_i,
  input  wire          pop_front_i,
  output sample_t      front_data_o,
  input  wire          push_back_i,
  input  wire sample_t back_data_i,
  output logic         empty_o,
  output logic         full_o,
  output length_t      length_o
);

  sram_addr_t back_addr_q;
  sram_addr_t front_addr;
  sram_addr_t rd_addr;
  sram_addr_t sram_addr;
  length_t    length_q;
  logic       pop_defer_q;
  logic       pop_defer_d;
  logic       refresh_q;
  logic       refresh_d;
  logic       pop_any;
  logic       sram_req;

  // a pop executes now or comes back from the previous cycle
  assign pop_any = pop_front_i | pop_defer_q;

  // sram port is busy with the write, so the pop moves one cycle later
  assign pop_defer_d = pop_front_i & (push_back_i | pop_defer_q);

  // first word into an empty register must still be read out to the front
  // keep waiting while pushes occupy the port
  assign refresh_d = (push_back_i & empty_o) | (refresh_q & push_back_i);

  // oldest word sits length entries behind the write pointer, wraps mod NUM_WORDS
  assign front_addr = back_addr_q - sram_addr_t'(length_q);
  // on a pop read the word behind the front instead
  assign rd_addr    = pop_any ? front_addr + sram_addr_t'(1) : front_addr;
  assign sram_addr  = push_back_i ? back_addr_q : rd_addr;
  assign sram_req   = push_back_i | pop_any | refresh_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      back_addr_q <= '0;
      length_q    <= '0;
      pop_defer_q <= 1'b0;
      refresh_q   <= 1'b0;
    end else if (clear_i) begin
      // flush, stored words become unreachable
      back_addr_q <= '0;
      length_q    <= '0;
      pop_defer_q <= 1'b0;
      refresh_q   <= 1'b0;
    end else begin
      pop_defer_q <= pop_defer_d;
      refresh_q   <= refresh_d;
      if (push_back_i) begin
        back_addr_q <= back_addr_q + sram_addr_t'(1);
        length_q    <= length_q + length_t'(1);
      end else if (pop_any) begin
        length_q <= length_q - length_t'(1);
      end
    end
  end

  assign empty_o  = (length_q == '0);
  assign full_o   = (length_q == length_t'(NUM_WORDS));
  assign length_o = length_q;

  sp_sram u_sram (
    .clk_i   (clk_i),
    .req_i   (sram_req),
    .we_i    (push_back_i),
    .addr_i  (sram_addr),
    .wdata_i (back_data_i),
    .rdata_o (front_data_o)
  );

  // controller must not pop an empty register
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(pop_front_i && empty_o));
  // nor push into a full one
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(push_back_i && full_o));
  // only one pop can wait behind a push
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(pop_front_i && push_back_i && pop_defer_q));

endmodule

`default_nettype wire

// File: hw/delay_line_ctrl.sv
// delay line controller: pushes samples, pops the oldest one past depth and emits it
`timescale 1ns/1ps
`default_nettype none

module delay_line_ctrl import dl_data_pkg::*; (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  wire                 enable_i,
  input  wire length_t        depth_i,
  input  wire                 clear_i,
  input  wire sample_stream_t in_i,
  output sample_stream_t      out_o,
  output logic                out_fire_o,
  output logic                sr_push_o,
  output sample_t             sr_data_o,
  output logic                sr_pop_o,
  output logic                sr_clear_o,
  input  wire sample_t        sr_front_i,
  input  wire length_t        sr_length_i
);

  typedef enum logic [1:0] {
    IDLE,
    POP,
    EMIT,
    SETTLE
  } state_e;

  state_e  state_q;
  state_e  state_d;
  logic    accept;
  logic    pop_due;
  logic    pend_q;
  logic    pend_d;
  logic    out_valid_q;
  sample_t out_sample_q;

  // input is dropped while disabled or while the register is being flushed
  assign accept  = in_i.valid & enable_i & ~clear_i;
  // register already holds depth samples before this push
  assign pop_due = accept & (sr_length_i == depth_i);

  assign sr_push_o  = accept;
  assign sr_data_o  = in_i.sample;
  assign sr_clear_o = clear_i;
  // a clear in the pop cycle wins, nothing leaves
  assign sr_pop_o   = (state_q == POP) & ~clear_i;

  always_comb begin
    state_d = state_q;
    pend_d  = pend_q;
    case (state_q)
      IDLE: begin
        if (pop_due) begin
          state_d = POP;
        end
      end
      POP: begin
        pend_d  = pend_q | pop_due;
        state_d = EMIT;
      end
      EMIT: begin
        // front word still settling, remember a late pop request
        pend_d  = pend_q | pop_due;
        state_d = SETTLE;
      end
      SETTLE: begin
        if (pop_due || pend_q) begin
          pend_d  = 1'b0;
          state_d = POP;
        end else begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      state_q     <= IDLE;
      pend_q      <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      pend_q      <= pend_d;
      out_valid_q <= (state_q == POP);
    end
  end

  // front word is captured in the pop cycle, before the read port moves on
  always_ff @(posedge clk_i) begin
    if (state_q == POP) begin
      out_sample_q <= sr_front_i;
    end
  end

  assign out_o      = '{valid: out_valid_q, sample: out_sample_q};
  assign out_fire_o = out_valid_q;

  // upstream spacing rule, the pop and settle slots depend on it
  assert property (@(posedge clk_i) disable iff (!rst_n_i) accept |=> !in_i.valid [*2]);

endmodule

`default_nettype wire

// File: hw/delay_line_regs.sv
// AXI4-Lite register block for the delay line: control, depth, status and output count
`timescale 1ns/1ps
`default_nettype none

module delay_line_regs import dl_bus_pkg::*, dl_data_pkg::*; (
  input  wire            clk_i,
  input  wire            rst_n_i,
  input  wire axil_req_t axil_req_i,
  output axil_rsp_t      axil_rsp_o,
  output logic           enable_o,
  output length_t        depth_o,
  output logic           clear_o,
  input  wire            out_fire_i,
  input  wire length_t   length_i,
  input  wire            empty_i,
  input  wire            full_i
);

  logic       wr_en;
  logic       rd_en;
  logic       bvalid_q;
  logic       rvalid_q;
  axil_data_t rdata_q;
  axil_data_t rd_word;
  logic       enable_q;
  logic       clear_q;
  length_t    depth_q;
  length_t    depth_wr;
  axil_data_t out_count_q;

  // address and data must arrive together, one write in flight
  assign wr_en = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
  // one read in flight
  assign rd_en = axil_req_i.arvalid & ~rvalid_q;

  assign axil_rsp_o = '{
    awready: wr_en,
    wready:  wr_en,
    bvalid:  bvalid_q,
    arready: ~rvalid_q,
    rdata:   rdata_q,
    rvalid:  rvalid_q
  };

  // written depth is clamped into the legal delay range
  always_comb begin
    if (axil_req_i.wdata < DEPTH_MIN) begin
      depth_wr = length_t'(DEPTH_MIN);
    end else if (axil_req_i.wdata > DEPTH_MAX) begin
      depth_wr = length_t'(DEPTH_MAX);
    end else begin
      depth_wr = length_t'(axil_req_i.wdata);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bvalid_q    <= 1'b0;
      enable_q    <= 1'b0;
      clear_q     <= 1'b0;
      depth_q     <= length_t'(DEPTH_RESET);
      out_count_q <= '0;
    end else begin
      // clear only lasts one cycle
      clear_q <= 1'b0;
      if (wr_en) begin
        bvalid_q <= 1'b1;
        case (axil_req_i.awaddr)
          REG_CTRL: begin
            enable_q <= axil_req_i.wdata[CTRL_ENABLE_BIT];
            clear_q  <= axil_req_i.wdata[CTRL_CLEAR_BIT];
          end
          REG_DEPTH: begin
            // depth is frozen while the line runs
            if (!enable_q) begin
              depth_q <= depth_wr;
            end
          end
          default: ;
        endcase
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      // wraps at 32 bits
      if (out_fire_i) begin
        out_count_q <= out_count_q + axil_data_t'(1);
      end
    end
  end

  // read mux, unknown offsets give zero
  always_comb begin
    rd_word = '0;
    case (axil_req_i.araddr)
      REG_CTRL:      rd_word[CTRL_ENABLE_BIT] = enable_q;
      REG_DEPTH:     rd_word[$bits(length_t)-1:0] = depth_q;
      REG_STATUS: begin
        rd_word[STATUS_LENGTH_LSB +: $bits(length_t)] = length_i;
        rd_word[STATUS_EMPTY_BIT] = empty_i;
        rd_word[STATUS_FULL_BIT]  = full_i;
      end
      REG_OUT_COUNT: rd_word = out_count_q;
      default:       rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_en) begin
      rvalid_q <= 1'b1;
    end else if (axil_req_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // read data held until rready
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rd_word;
    end
  end

  assign enable_o = enable_q;
  assign depth_o  = depth_q;
  assign clear_o  = clear_q;

endmodule

`default_nettype wire

// File: hw/delay_line_top.sv
// delay line top: register block, controller and SRAM shift register
`timescale 1ns/1ps
`default_nettype none

module delay_line_top import dl_bus_pkg::*, dl_data_pkg::*; (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  wire axil_req_t      axil_req_i,
  output axil_rsp_t           axil_rsp_o,
  input  wire sample_stream_t in_i,
  output sample_stream_t      out_o
);

  // register block to controller
  logic    enable;
  length_t depth;
  logic    clear_pulse;
  logic    out_fire;

  // controller to shift register
  logic    sr_push;
  sample_t sr_data;
  logic    sr_pop;
  logic    sr_clear;
  sample_t sr_front;

  // shift register status, shared by controller and status register
  length_t sr_length;
  logic    sr_empty;
  logic    sr_full;

  delay_line_regs u_regs (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .enable_o   (enable),
    .depth_o    (depth),
    .clear_o    (clear_pulse),
    .out_fire_i (out_fire),
    .length_i   (sr_length),
    .empty_i    (sr_empty),
    .full_i     (sr_full)
  );

  delay_line_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .enable_i    (enable),
    .depth_i     (depth),
    .clear_i     (clear_pulse),
    .in_i        (in_i),
    .out_o       (out_o),
    .out_fire_o  (out_fire),
    .sr_push_o   (sr_push),
    .sr_data_o   (sr_data),
    .sr_pop_o    (sr_pop),
    .sr_clear_o  (sr_clear),
    .sr_front_i  (sr_front),
    .sr_length_i (sr_length)
  );

  sram_shift_reg u_shreg (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .clear_i      (sr_clear),
    .pop_front_i  (sr_pop),
    .front_data_o (sr_front),
    .push_back_i  (sr_push),
    .back_data_i  (sr_data),
    .empty_o      (sr_empty),
    .full_o       (sr_full),
    .length_o     (sr_length)
  );

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
// testbench clock and reset source, 10 ns clock with reset held low for three cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // free-running clock, 5 ns per phase
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset is synchronous, released on the third rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: verif/delay_line_checker.sv
// testbench monitor: models the delay in a queue and compares output samples and register values
`timescale 1ns/1ps
`default_nettype none

module delay_line_checker import dl_bus_pkg::*, dl_data_pkg::*; (
  input wire                 clk_i,
  input wire                 rst_n_i,
  input wire sample_stream_t in_i,
  input wire sample_stream_t out_i,
  input wire                 enable_i,
  input wire length_t        depth_i
);

  // samples the DUT has accepted and not yet emitted, oldest first
  sample_t     exp_q [$];
  int unsigned err_count = 0;
  int unsigned out_seen = 0;

  always @(posedge clk_i) begin : watch_stream
    sample_t exp_s;
    if (rst_n_i) begin
      // output side first, a new input in the same edge cannot be the one leaving
      if (out_i.valid) begin
        out_seen++;
        if (exp_q.size() > int'(depth_i)) begin
          exp_s = exp_q.pop_front();
          if (out_i.sample !== exp_s) begin
            $display("mismatch at time %0t: out_o.sample expected 0x%08h actual 0x%08h",
                     $time, exp_s, out_i.sample);
            err_count++;
          end
        end else begin
          $display("error at time %0t: output 0x%08h appeared with only %0d samples stored",
                   $time, out_i.sample, exp_q.size());
          err_count++;
        end
      end
      // samples while disabled are dropped by the DUT
      if (in_i.valid && enable_i) begin
        exp_q.push_back(in_i.sample);
      end
    end
  end

  // a clear flushes everything still stored
  task automatic flush_queue();
    exp_q.delete();
  endtask

  // compare one value read back from the DUT
  task automatic compare_value(input string name, input axil_data_t exp_v,
                               input axil_data_t act_v);
    if (act_v !== exp_v) begin
      $display("mismatch at time %0t: %s expected 0x%08h actual 0x%08h",
               $time, name, exp_v, act_v);
      err_count++;
    end
  endtask

endmodule

`default_nettype wire

// File: verif/tb_delay_line.sv
// testbench top for the delay line with bus tasks, a stimulus table, the timeout and the summary
`timescale 1ns/1ps
`default_nettype none

module tb_delay_line import dl_bus_pkg::*, dl_data_pkg::*; ();

  // one table row holds the depth to write, the depth read back, the sample count and a clear flag
  typedef struct packed {
    axil_data_t wr_depth;
    length_t    exp_depth;
    logic [7:0] num_samples;
    logic       mid_clear;
  } row_t;

  localparam int unsigned NUM_ROWS          = 5;
  localparam int unsigned CYCLES_PER_SAMPLE = 5;
  localparam int unsigned TIMEOUT_BASE      = 200;
  localparam int unsigned DRAIN_CYCLES      = 6;
  // depth written while enabled that no row uses
  localparam axil_data_t  LOCKED_DEPTH      = 32'd40;

  logic           clk;
  logic           rst_n;
  axil_req_t      bus_req;
  axil_rsp_t      bus_rsp;
  sample_stream_t stream_in;
  sample_stream_t stream_out;

  // reference state mirrored from what the testbench has programmed
  logic           exp_enable;
  length_t        exp_depth_q;
  int unsigned    exp_out_total;

  row_t           rows [NUM_ROWS];
  int unsigned    cycle_count = 0;
  int unsigned    cycle_limit = 0;
  int unsigned    tests_passed = 0;
  int unsigned    tests_failed = 0;

  tb_clk_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  delay_line_top u_dut (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .axil_req_i (bus_req),
    .axil_rsp_o (bus_rsp),
    .in_i       (stream_in),
    .out_o      (stream_out)
  );

  delay_line_checker u_chk (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .in_i     (stream_in),
    .out_i    (stream_out),
    .enable_i (exp_enable),
    .depth_i  (exp_depth_q)
  );

  function automatic row_t make_row(input axil_data_t wr_depth, input length_t exp_depth,
                                    input logic [7:0] num_samples, input logic mid_clear);
    row_t r;
    r.wr_depth    = wr_depth;
    r.exp_depth   = exp_depth;
    r.num_samples = num_samples;
    r.mid_clear   = mid_clear;
    return r;
  endfunction

  // STATUS holds the length in the low bits and empty at bit 8 while full stays clear here
  function automatic axil_data_t status_word(input int unsigned len);
    axil_data_t w;
    w = axil_data_t'(len);
    w[STATUS_EMPTY_BIT] = (len == 0);
    return w;
  endfunction

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(posedge clk);
  endtask

  // address and data go out together and the response is taken with bready high
  task automatic bus_write(input axil_addr_t addr, input axil_data_t data);
    @(posedge clk);
    bus_req.awaddr  <= addr;
    bus_req.awvalid <= 1'b1;
    bus_req.wdata   <= data;
    bus_req.wvalid  <= 1'b1;
    bus_req.bready  <= 1'b1;
    do @(posedge clk); while (!bus_rsp.awready);
    // wready rises in the same cycle as awready
    u_chk.compare_value("wready", axil_data_t'(1), axil_data_t'(bus_rsp.wready));
    bus_req.awvalid <= 1'b0;
    bus_req.wvalid  <= 1'b0;
    do @(posedge clk); while (!bus_rsp.bvalid);
    bus_req.bready  <= 1'b0;
  endtask

  task automatic bus_read(input axil_addr_t addr, output axil_data_t data);
    @(posedge clk);
    bus_req.araddr  <= addr;
    bus_req.arvalid <= 1'b1;
    bus_req.rready  <= 1'b1;
    do @(posedge clk); while (!bus_rsp.arready);
    bus_req.arvalid <= 1'b0;
    do @(posedge clk); while (!bus_rsp.rvalid);
    data = bus_rsp.rdata;
    bus_req.rready  <= 1'b0;
  endtask

  task automatic check_reg(input axil_addr_t addr, input string name, input axil_data_t exp_v);
    axil_data_t act_v;
    bus_read(addr, act_v);
    u_chk.compare_value(name, exp_v, act_v);
  endtask

  // one valid cycle and the next sample gap cycles later
  task automatic send_sample(input sample_t s, input int unsigned gap);
    @(posedge clk);
    stream_in.sample <= s;
    stream_in.valid  <= 1'b1;
    @(posedge clk);
    stream_in.valid  <= 1'b0;
    repeat (gap - 2) @(posedge clk);
  endtask

  // random samples 3 to 5 cycles apart followed by a drain and a check of the fill level
  task automatic run_segment(input int unsigned n, input length_t depth);
    int unsigned gap;
    int unsigned len;
    for (int unsigned i = 0; i < n; i++) begin
      gap = 3 + ($urandom % 3);
      send_sample(sample_t'($urandom), gap);
    end
    wait_cycles(DRAIN_CYCLES);
    // every sample past the first depth ones pushes one out
    if (n > depth) begin
      exp_out_total += n - depth;
      len = depth;
    end else begin
      len = n;
    end
    check_reg(REG_STATUS, "STATUS", status_word(len));
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    int unsigned errs;
    errs = u_chk.err_count - errs_before;
    if (errs == 0) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errs);
    end
  endtask

  task automatic run_row(input int unsigned idx, input row_t r);
    int unsigned errs_before;
    int unsigned seg;
    errs_before = u_chk.err_count;
    // depth is programmed with the line disabled
    bus_write(REG_DEPTH, r.wr_depth);
    exp_depth_q <= r.exp_depth;
    check_reg(REG_DEPTH, "DEPTH", axil_data_t'(r.exp_depth));
    // dropped while disabled
    send_sample(sample_t'($urandom), 3);
    check_reg(REG_STATUS, "STATUS", status_word(0));
    bus_write(REG_CTRL, axil_data_t'(1) << CTRL_ENABLE_BIT);
    exp_enable <= 1'b1;
    // depth is locked while enabled
    bus_write(REG_DEPTH, LOCKED_DEPTH);
    check_reg(REG_DEPTH, "DEPTH", axil_data_t'(r.exp_depth));
    seg = r.num_samples;
    if (r.mid_clear) begin
      seg = r.num_samples / 2;
      run_segment(seg, r.exp_depth);
      bus_write(REG_CTRL, (axil_data_t'(1) << CTRL_ENABLE_BIT) |
                          (axil_data_t'(1) << CTRL_CLEAR_BIT));
      u_chk.flush_queue();
      check_reg(REG_STATUS, "STATUS", status_word(0));
      seg = r.num_samples - seg;
    end
    run_segment(seg, r.exp_depth);
    check_reg(REG_OUT_COUNT, "OUT_COUNT", exp_out_total);
    u_chk.compare_value("outputs seen", exp_out_total, u_chk.out_seen);
    // disable and flush together for the next row
    bus_write(REG_CTRL, axil_data_t'(1) << CTRL_CLEAR_BIT);
    exp_enable <= 1'b0;
    u_chk.flush_queue();
    check_reg(REG_STATUS, "STATUS", status_word(0));
    report_test($sformatf("row %0d depth %0d samples %0d clear %0d", idx, r.exp_depth,
                          r.num_samples, r.mid_clear), errs_before);
  endtask

  // hang guard
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin : main_seq
    int unsigned seed;
    int unsigned errs_before;
    seed = 32'ha989aa1e;
    void'($urandom(seed));
    bus_req       = '0;
    stream_in     = '0;
    exp_enable    = 1'b0;
    exp_depth_q   = length_t'(1);
    exp_out_total = 0;
    rows[0] = make_row(32'd1, length_t'(1), 8'd20, 1'b0);
    rows[1] = make_row(32'd5, length_t'(5), 8'd40, 1'b1);
    rows[2] = make_row(32'd63, length_t'(63), 8'd130, 1'b0);
    // out-of-range writes clamp to the legal range
    rows[3] = make_row(32'd0, length_t'(1), 8'd12, 1'b0);
    rows[4] = make_row(32'd64, length_t'(63), 8'd80, 1'b0);
    // five cycles per sample covers the widest spacing
    cycle_limit = TIMEOUT_BASE;
    for (int unsigned i = 0; i < NUM_ROWS; i++) begin
      cycle_limit += CYCLES_PER_SAMPLE * rows[i].num_samples;
    end
    @(posedge rst_n);
    @(posedge clk);
    // register values after reset
    errs_before = u_chk.err_count;
    check_reg(REG_CTRL, "CTRL", 32'd0);
    check_reg(REG_DEPTH, "DEPTH", 32'd1);
    check_reg(REG_STATUS, "STATUS", status_word(0));
    check_reg(REG_OUT_COUNT, "OUT_COUNT", 32'd0);
    report_test("reset values", errs_before);
    for (int unsigned i = 0; i < NUM_ROWS; i++) begin
      run_row(i, rows[i]);
    end
    wait_cycles(2);
    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, u_chk.err_count);
    if (tests_failed == 0 && u_chk.err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
hw/dl_bus_pkg.sv
hw/dl_data_pkg.sv
hw/sp_sram.sv
hw/sram_shift_reg.sv
hw/delay_line_ctrl.sv
hw/delay_line_regs.sv
hw/delay_line_top.sv
verif/tb_clk_gen.sv
verif/delay_line_checker.sv
verif/tb_delay_line.sv

// File: Bender.yml
package:
  name: delay_line

sources:
  - files:
      - hw/dl_bus_pkg.sv
      - hw/dl_data_pkg.sv
      - hw/sp_sram.sv
      - hw/sram_shift_reg.sv
      - hw/delay_line_ctrl.sv
      - hw/delay_line_regs.sv
      - hw/delay_line_top.sv
  - target: simulation
    files:
      - verif/tb_clk_gen.sv
      - verif/delay_line_checker.sv
      - verif/tb_delay_line.sv
